/* design/wbb_addr_gen.sv */
// Wrapping burst address generator, loaded and stepped by the bus control block
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_addr_gen (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_i,
  input  logic [`WBB_ADDR_W-1:0] start_adr_i,
  input  logic                   step_i,
  output logic [`WBB_ADDR_W-1:0] adr_o,
  output logic                   wrap_last_o
);

  localparam int BB = `WBB_BURST_BITS;

  logic [`WBB_ADDR_W-1:2] word_q;       // Current word address
  logic [BB-1:0]          start_idx_q;  // Index the burst began at
  logic [BB-1:0]          next_idx;

  assign next_idx = word_q[BB+1:2] + 1'b1;  // Wraps inside the block

  always_ff @(posedge clk) begin
    if (rst) begin
      word_q      <= '0;
      start_idx_q <= '0;
    end else if (load_i) begin
      word_q      <= start_adr_i[`WBB_ADDR_W-1:2];
      start_idx_q <= start_adr_i[BB+1:2];
    end else if (step_i) begin
      // Upper bits stay put, block is aligned
      word_q[BB+1:2] <= next_idx;
    end
  end

  assign adr_o = {word_q, 2'b00};

  // Next beat would revisit the start index, so this one ends the burst
  assign wrap_last_o = (next_idx == start_idx_q);

endmodule

/* design/wbb_bus_ctrl.sv */
// Wishbone master FSM, runs classic cycles and wrapping read bursts and forms response beats
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_bus_ctrl import wbb_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   head_valid_i,
  input  cpu_req_t               head_i,
  output logic                   pop_o,
  output logic                   load_o,
  output logic                   step_o,
  input  logic [`WBB_ADDR_W-1:0] burst_adr_i,
  input  logic                   wrap_last_i,
  output wb_m2s_t                wb_o,
  input  wb_s2m_t                wb_i,
  output logic                   rsp_valid_o,
  output cpu_rsp_t               rsp_o
);

  // Wrap length code for bte
  localparam logic [1:0] BTE_WRAP = (`WBB_BURST_LEN == 4)  ? 2'b01 :
                                    (`WBB_BURST_LEN == 8)  ? 2'b10 :
                                    (`WBB_BURST_LEN == 16) ? 2'b11 : 2'b00;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SINGLE,
    ST_BURST,
    ST_FINISH
  } state_e;

  state_e   state_q;
  state_e   state_d;
  cpu_req_t req_q;       // Request being run on the bus
  logic     active;
  logic     start_burst;
  logic     beat_done;
  logic     beat_last;

  assign active      = (state_q == ST_SINGLE) || (state_q == ST_BURST);
  assign pop_o       = (state_q == ST_IDLE) && head_valid_i;
  assign start_burst = head_i.burst && !head_i.we;  // Write bursts run as single
  assign load_o      = pop_o && start_burst;
  assign step_o      = (state_q == ST_BURST) && wb_i.ack;

  assign beat_done = active && (wb_i.ack || wb_i.err);
  assign beat_last = wb_i.err || (state_q == ST_SINGLE) || wrap_last_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (head_valid_i)
          state_d = start_burst ? ST_BURST : ST_SINGLE;
      end
      ST_SINGLE: begin
        if (wb_i.ack || wb_i.err)
          state_d = ST_FINISH;
      end
      ST_BURST: begin
        if (wb_i.err || (wb_i.ack && wrap_last_i))
          state_d = ST_FINISH;
      end
      default: state_d = ST_IDLE;  // Finish, bus idle for a cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (pop_o)
      req_q <= head_i;
  end

  // Bus outputs
  always_comb begin
    wb_o.adr = req_q.adr;
    wb_o.dat = req_q.dat;
    wb_o.sel = req_q.sel;
    wb_o.we  = req_q.we;
    wb_o.cyc = active;
    wb_o.stb = active;
    wb_o.cti = CTI_CLASSIC;
    wb_o.bte = 2'b00;
    if (state_q == ST_BURST) begin
      wb_o.adr = burst_adr_i;  // Generator walks the wrap
      wb_o.cti = wrap_last_i ? CTI_EOB : CTI_INCR;
      wb_o.bte = BTE_WRAP;
    end
  end

  // Response beat, one cycle after ack or err
  always_ff @(posedge clk) begin
    if (rst)
      rsp_valid_o <= 1'b0;
    else
      rsp_valid_o <= beat_done;
  end

  always_ff @(posedge clk) begin
    if (beat_done) begin
      rsp_o.dat  <= wb_i.err ? '0 : wb_i.dat;
      rsp_o.err  <= wb_i.err;
      rsp_o.last <= beat_last;
      rsp_o.we   <= req_q.we;
    end
  end

endmodule

/* design/wbb_defs.svh */
// Bridge sizing macros, included by every design file that needs burst, credit or memory sizes
`ifndef WBB_DEFS_SVH
`define WBB_DEFS_SVH

// Words per wrapping read burst
`define WBB_BURST_LEN 8

// Word-index bits that wrap inside one burst block
`define WBB_BURST_BITS 3

// Request queue depth and initial sender credits
`define WBB_REQ_CREDITS 4

// SRAM size in 32-bit words, higher word addresses get err
`define WBB_MEM_WORDS 256

// Byte address width on both ports
`define WBB_ADDR_W 32

`endif

/* design/wbb_pkg.sv */
// Shared request, response and Wishbone bundle types, imported by the bridge modules
`include "wbb_defs.svh"

package wbb_pkg;

  // Wishbone B3 cycle type identifiers
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } wb_cti_e;

  // CPU side request, 70 bits
  typedef struct packed {
    logic [`WBB_ADDR_W-1:0] adr;
    logic [31:0]            dat;
    logic [3:0]             sel;
    logic                   we;
    logic                   burst;  // Wrapping read burst
  } cpu_req_t;

  // CPU side response beat, 35 bits
  typedef struct packed {
    logic [31:0] dat;
    logic        err;
    logic        last;   // Final beat of the request
    logic        we;
  } cpu_rsp_t;

  // Master to slave
  typedef struct packed {
    logic [`WBB_ADDR_W-1:0] adr;
    logic [31:0]            dat;
    logic [3:0]             sel;
    logic                   we;
    logic                   cyc;
    logic                   stb;
    wb_cti_e                cti;
    logic [1:0]             bte;
  } wb_m2s_t;

  // Slave to master, no rty
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_s2m_t;

endpackage

/* design/wbb_req_fifo.sv */
// Credit-sized request queue between the CPU port and the bus control block
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_req_fifo import wbb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_i,
  input  cpu_req_t req_i,
  input  logic     pop_i,
  output logic     head_valid_o,
  output cpu_req_t head_o,
  output logic     credit_o
);

  localparam int DEPTH = `WBB_REQ_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  cpu_req_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage, sender guarantees a free slot
  always_ff @(posedge clk) begin
    if (push_i)
      mem[wr_ptr] <= req_i;
  end

  // One credit back per popped entry
  always_ff @(posedge clk) begin
    if (rst)
      credit_o <= 1'b0;
    else
      credit_o <= pop_i;
  end

  assign head_valid_o = (count != '0);
  assign head_o       = mem[rd_ptr];

endmodule

/* design/wbb_sram_slave.sv */
// On-chip SRAM Wishbone slave with registered ack, burst streaming and range error
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_sram_slave import wbb_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  wb_m2s_t wb_i,
  output wb_s2m_t wb_o
);

  localparam int WORDS  = `WBB_MEM_WORDS;
  localparam int IDX_W  = $clog2(WORDS);
  localparam int WORD_W = `WBB_ADDR_W - 2;
  localparam int BB     = `WBB_BURST_BITS;

  logic [31:0]       mem [WORDS];
  logic [31:0]       dat_q;
  logic              ack_q;
  logic              err_q;
  logic [WORD_W-1:0] rd_word;
  logic              beat_start;
  logic              beat_cont;
  logic              fire;
  logic              oor;

  // Same wrap rule as the master side
  function automatic logic [WORD_W-1:0] wrap_inc(input logic [WORD_W-1:0] w);
    logic [WORD_W-1:0] n;
    n = w;
    n[BB-1:0] = w[BB-1:0] + 1'b1;
    return n;
  endfunction

  assign beat_start = wb_i.cyc && wb_i.stb && !ack_q && !err_q;
  assign beat_cont  = wb_i.cyc && wb_i.stb && ack_q && (wb_i.cti == CTI_INCR);
  assign fire       = beat_start || beat_cont;

  // Acked beat moves on, so look one word ahead
  assign rd_word = ack_q ? wrap_inc(wb_i.adr[`WBB_ADDR_W-1:2]) : wb_i.adr[`WBB_ADDR_W-1:2];
  assign oor     = (rd_word >= WORD_W'(WORDS));

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= fire && !oor;
      err_q <= fire && oor;
    end
  end

  always_ff @(posedge clk) begin
    if (fire)
      dat_q <= mem[rd_word[IDX_W-1:0]];
    if (beat_start && wb_i.we && !oor) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_i.sel[b])
          mem[rd_word[IDX_W-1:0]][8*b +: 8] <= wb_i.dat[8*b +: 8];
      end
    end
  end

  assign wb_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

/* design/wbb_top.sv */
// Bridge top level, wires the request queue, bus control, address generator and SRAM slave
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_top import wbb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid_i,
  input  cpu_req_t req_i,
  output logic     credit_o,
  output logic     rsp_valid_o,
  output cpu_rsp_t rsp_o
);

  logic                   head_valid;
  cpu_req_t               head;
  logic                   pop;
  logic                   load;
  logic                   step;
  logic [`WBB_ADDR_W-1:0] burst_adr;
  logic                   wrap_last;
  wb_m2s_t                wb_m2s;
  wb_s2m_t                wb_s2m;

  wbb_req_fifo i_req_fifo (
    .clk          (clk),
    .rst          (rst),
    .push_i       (req_valid_i),  // Sender only pushes with a credit
    .req_i        (req_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (credit_o)
  );

  wbb_addr_gen i_addr_gen (
    .clk         (clk),
    .rst         (rst),
    .load_i      (load),
    .start_adr_i (head.adr),
    .step_i      (step),
    .adr_o       (burst_adr),
    .wrap_last_o (wrap_last)
  );

  wbb_bus_ctrl i_bus_ctrl (
    .clk          (clk),
    .rst          (rst),
    .head_valid_i (head_valid),
    .head_i       (head),
    .pop_o        (pop),
    .load_o       (load),
    .step_o       (step),
    .burst_adr_i  (burst_adr),
    .wrap_last_i  (wrap_last),
    .wb_o         (wb_m2s),
    .wb_i         (wb_s2m),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

  wbb_sram_slave i_sram_slave (
    .clk  (clk),
    .rst  (rst),
    .wb_i (wb_m2s),
    .wb_o (wb_s2m)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and scans the log for a failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module wbb_tb -o wbb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/wbb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi
exit 0

/* sim.f */
+incdir+design
design/wbb_pkg.sv
design/wbb_req_fifo.sv
design/wbb_addr_gen.sv
design/wbb_bus_ctrl.sv
design/wbb_sram_slave.sv
design/wbb_top.sv
verif/wbb_props.sv
verif/wbb_tb.sv

/* verif/wbb_props.sv */
// Queue and Wishbone handshake checks, bound into the bridge top level by the bind below
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_props import wbb_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    push_i,
  input logic    pop_i,
  input logic    rsp_valid_i,
  input wb_m2s_t wb_m2s_i,
  input wb_s2m_t wb_s2m_i
);

  localparam int OCC_W = $clog2(`WBB_REQ_CREDITS) + 1;
  localparam logic [OCC_W-1:0] FULL = OCC_W'(`WBB_REQ_CREDITS);

  logic [OCC_W-1:0] occ;  // Shadow queue occupancy

  always_ff @(posedge clk) begin
    if (rst)
      occ <= '0;
    else if (push_i && !pop_i)
      occ <= occ + 1'b1;
    else if (pop_i && !push_i)
      occ <= occ - 1'b1;
  end

  no_full_push: assert property (@(posedge clk) disable iff (rst)
    push_i |-> (occ != FULL))
    else $error("Request pushed into a full queue");

  stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_m2s_i.stb |-> wb_m2s_i.cyc)
    else $error("stb raised outside a bus cycle");

  // Master holds the beat until the slave answers
  hold_beat: assert property (@(posedge clk) disable iff (rst)
    (wb_m2s_i.cyc && wb_m2s_i.stb && !(wb_s2m_i.ack || wb_s2m_i.err))
      |=> (wb_m2s_i.cyc && wb_m2s_i.stb && $stable(wb_m2s_i.adr)))
    else $error("cyc, stb or adr changed before ack or err");

  eob_in_burst: assert property (@(posedge clk) disable iff (rst)
    (wb_m2s_i.cti == CTI_EOB) |-> (wb_m2s_i.cyc && wb_m2s_i.bte != 2'b00))
    else $error("End-of-burst cycle type outside a burst");

  rsp_after_ack: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_i |-> $past(wb_s2m_i.ack || wb_s2m_i.err))
    else $error("Response beat without a preceding ack or err");

endmodule

bind wbb_top wbb_props i_wbb_props (
  .clk         (clk),
  .rst         (rst),
  .push_i      (req_valid_i),
  .pop_i       (pop),
  .rsp_valid_i (rsp_valid_o),
  .wb_m2s_i    (wb_m2s),
  .wb_s2m_i    (wb_s2m)
);

/* verif/wbb_tb.sv */
// Directed testbench for the Wishbone bridge top level, compiled from sim.f with the props bound in
`timescale 1ns/1ps
`include "wbb_defs.svh"

module wbb_tb import wbb_pkg::*; ();

  localparam int CLK_NS      = 8;
  localparam int RST_CYCLES  = 4;
  localparam int IDX_W       = $clog2(`WBB_MEM_WORDS);
  localparam int REQ_CYCLES  = `WBB_BURST_LEN + 8;  // Worst request incl. queue wait
  localparam int N_WR        = 8;
  localparam int N_REQS      = 4 + 2 * N_WR + 9 + 9 + 5;
  localparam int WATCHDOG_NS = (RST_CYCLES + 2 + N_REQS * REQ_CYCLES) * 4 * CLK_NS;

  logic        clk;
  logic        rst;
  logic        req_valid;
  cpu_req_t    req;
  logic        credit;
  logic        rsp_valid;
  cpu_rsp_t    rsp;
  logic [31:0] ref_mem [`WBB_MEM_WORDS];  // Reference memory model
  logic [31:0] rng_state;
  cpu_rsp_t    rsp_q[$];
  cpu_rsp_t    got_q[$];                   // Beats of the last finished request
  int          sent_cnt;
  int          credits_back;
  int          value_errs;
  int          other_errs;

  wbb_top i_wbb_top (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_i       (req),
    .credit_o    (credit),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && rsp_valid)
      rsp_q.push_back(rsp);
    if (!rst && credit)
      credits_back++;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_beat(input int i, input logic exp_we, input logic exp_err,
                            input logic exp_last, input logic chk_dat,
                            input logic [31:0] exp_dat);
    if (i < got_q.size()) begin
      check_val("rsp_o.we", 32'(got_q[i].we), 32'(exp_we));
      check_val("rsp_o.err", 32'(got_q[i].err), 32'(exp_err));
      check_val("rsp_o.last", 32'(got_q[i].last), 32'(exp_last));
      if (chk_dat)
        check_val("rsp_o.dat", got_q[i].dat, exp_dat);
    end
  endtask

  // Called on a rising edge, spends one credit
  task automatic send_req(input logic [31:0] word, input logic [31:0] dat, input logic [3:0] sel,
                          input logic we, input logic burst);
    while (`WBB_REQ_CREDITS + credits_back - sent_cnt == 0)
      @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{adr: {word[29:0], 2'b00}, dat: dat, sel: sel, we: we, burst: burst};
    sent_cnt++;
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_rsp(input int exp_beats);
    cpu_rsp_t b;
    int       cycles;
    bit       done;
    cycles = 0;
    done   = 1'b0;
    got_q.delete();
    while (!done && cycles < 4 * REQ_CYCLES) begin
      @(posedge clk);
      cycles++;
      while (!done && rsp_q.size() > 0) begin
        b = rsp_q.pop_front();
        got_q.push_back(b);
        done = b.last;
      end
    end
    assert (done) else begin
      $display("No final response beat arrived within %0d cycles", 4 * REQ_CYCLES);
      other_errs++;
    end
    check_val("beat count", got_q.size(), exp_beats);
  endtask

  task automatic write_word(input logic [31:0] word, input logic [31:0] dat, input logic [3:0] sel);
    send_req(word, dat, sel, 1'b1, 1'b0);
    ref_mem[IDX_W'(word)] = merge_bytes(ref_mem[IDX_W'(word)], dat, sel);
    wait_rsp(1);
    check_beat(0, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
  endtask

  task automatic read_word(input logic [31:0] word);
    send_req(word, 32'h0, 4'hf, 1'b0, 1'b0);
    wait_rsp(1);
    check_beat(0, 1'b0, 1'b0, 1'b1, 1'b1, ref_mem[IDX_W'(word)]);
  endtask

  // Four requests on the initial credits, answered in order
  task automatic credit_flow();
    int          pulses0;
    logic [31:0] d0;
    logic [31:0] d1;
    pulses0 = credits_back;
    d0 = lcg_next();
    d1 = lcg_next();
    send_req(32'h40, d0, 4'hf, 1'b1, 1'b0);
    send_req(32'h41, d1, 4'hf, 1'b1, 1'b0);
    send_req(32'h40, 32'h0, 4'hf, 1'b0, 1'b0);
    send_req(32'h41, 32'h0, 4'hf, 1'b0, 1'b0);
    for (int i = 0; i < 2; i++) begin
      wait_rsp(1);
      check_beat(0, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
    end
    wait_rsp(1);
    check_beat(0, 1'b0, 1'b0, 1'b1, 1'b1, d0);
    wait_rsp(1);
    check_beat(0, 1'b0, 1'b0, 1'b1, 1'b1, d1);
    ref_mem[IDX_W'(32'h40)] = d0;
    ref_mem[IDX_W'(32'h41)] = d1;
    check_val("credit_o pulses", credits_back - pulses0, 4);
  endtask

  task automatic write_then_read();
    logic [31:0] words [N_WR];
    for (int i = 0; i < N_WR; i++) begin
      words[i] = 32'h80 + ((lcg_next() >> 16) & 32'h7f);
      write_word(words[i], lcg_next(), 4'hf);
    end
    for (int i = 0; i < N_WR; i++)
      read_word(words[i]);
  endtask

  task automatic byte_select();
    logic [3:0] sels [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    write_word(32'h20, lcg_next(), 4'hf);
    for (int i = 0; i < 4; i++) begin
      write_word(32'h20, lcg_next(), sels[i]);
      read_word(32'h20);
    end
  endtask

  // Start at index 5, expect 5 6 7 0 1 2 3 4
  task automatic wrap_burst();
    for (int i = 0; i < `WBB_BURST_LEN; i++)
      write_word(32'h10 + i, lcg_next(), 4'hf);
    send_req(32'h15, 32'h0, 4'hf, 1'b0, 1'b1);
    wait_rsp(`WBB_BURST_LEN);
    for (int i = 0; i < `WBB_BURST_LEN; i++)
      check_beat(i, 1'b0, 1'b0, (i == `WBB_BURST_LEN - 1), 1'b1,
                 ref_mem[IDX_W'(32'h10 + (5 + i) % `WBB_BURST_LEN)]);
  endtask

  task automatic range_error();
    write_word(32'h0, lcg_next(), 4'hf);
    send_req(`WBB_MEM_WORDS, lcg_next(), 4'hf, 1'b1, 1'b0);  // Aliases word 0 if decoded short
    wait_rsp(1);
    check_beat(0, 1'b1, 1'b1, 1'b1, 1'b1, 32'h0);
    send_req(`WBB_MEM_WORDS, 32'h0, 4'hf, 1'b0, 1'b0);
    wait_rsp(1);
    check_beat(0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0);
    send_req(32'h3fff_ffff, 32'h0, 4'hf, 1'b0, 1'b0);
    wait_rsp(1);
    check_beat(0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0);
    read_word(32'h0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    rng_state    = 32'd28;
    sent_cnt     = 0;
    credits_back = 0;
    value_errs   = 0;
    other_errs   = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    credit_flow();
    write_then_read();
    byte_select();
    wrap_burst();
    range_error();
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
